// ==== source/fetch_consts.svh ====
////////////////////////////////////////
// fetch stage constants
// reset pc, ebreak encoding, parcel width
////////////////////////////////////////

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0080

// full 32-bit ebreak, target of c.ebreak
`define EBREAK_INSTR 32'h0010_0073

// one instruction parcel, half a fetch word
`define HALF_W 16

`endif

// ==== source/riscv_isa_pkg.sv ====
////////////////////////////////////////
// ISA types shared by decode logic
// major opcodes and compressed quadrants
////////////////////////////////////////

package riscv_isa_pkg;

  // major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // low two bits of a parcel
  // anything but 2'b11 is a 16-bit instruction
  typedef enum logic [1:0] {
    C0           = 2'b00,
    C1           = 2'b01,
    C2           = 2'b10,
    UNCOMPRESSED = 2'b11
  } quadrant_e;

endpackage

// ==== source/fetch_pkg.sv ====
////////////////////////////////////////
// fetch-side types
// address type and aligner state
////////////////////////////////////////

package fetch_pkg;

  // byte address of an instruction
  typedef logic [31:0] addr_t;

  // aligner state between fetch words
  // SKIP_LOW after a flush to pc[1] set
  typedef enum logic [1:0] {
    ALIGNED      = 2'd0,
    SKIP_LOW     = 2'd1,
    HALF_PENDING = 2'd2
  } align_state_e;

endpackage

// ==== source/instr_slot_if.sv ====
////////////////////////////////////////
// one decoded instruction slot
// decoder to stage register
////////////////////////////////////////

interface instr_slot_if import fetch_pkg::*; ();

  logic        valid;
  // expanded RV32 encoding
  logic [31:0] instr;
  addr_t       pc;
  logic        is_compressed;
  logic        illegal;

  // producer side
  modport decoder (output valid, instr, pc, is_compressed, illegal);

  // consumer side
  modport stage (input valid, instr, pc, is_compressed, illegal);

endinterface

// ==== source/compressed_decoder.sv ====
////////////////////////////////////////
// RV32C expander, purely combinational
// 32-bit instructions pass through
////////////////////////////////////////

`include "fetch_consts.svh"

module compressed_decoder import riscv_isa_pkg::*, fetch_pkg::*; (
  input  logic         cand_valid_i,
  input  logic [31:0]  cand_raw_i,
  input  addr_t        cand_pc_i,
  instr_slot_if.decoder slot_o
);

  // low parcel, upper half of cand_raw_i is don't-care when compressed
  logic [`HALF_W-1:0] ci;
  quadrant_e          quad;
  logic [31:0]        instr_exp;
  logic               illegal;

  assign ci   = cand_raw_i[`HALF_W-1:0];
  assign quad = quadrant_e'(cand_raw_i[1:0]);

  ////////////////////////////////////////
  // expansion
  ////////////////////////////////////////

  always_comb begin
    // default is pass through, legal
    instr_exp = cand_raw_i;
    illegal   = 1'b0;

    unique case (quad)
      C0: begin
        unique case (ci[15:13])
          3'b000: begin
            // c.addi4spn, addi rd', x2, nzuimm
            instr_exp = {2'b00, ci[10:7], ci[12:11], ci[5], ci[6], 2'b00,
                         5'd2, 3'b000, 2'b01, ci[4:2], OP_IMM};
            // zero imm, includes the all-zero parcel
            if (ci[12:5] == 8'b0) illegal = 1'b1;
          end
          3'b010: begin
            // c.lw
            instr_exp = {5'b0, ci[5], ci[12:10], ci[6], 2'b00, 2'b01, ci[9:7],
                         3'b010, 2'b01, ci[4:2], LOAD};
          end
          3'b110: begin
            // c.sw
            instr_exp = {5'b0, ci[5], ci[12], 2'b01, ci[4:2], 2'b01, ci[9:7],
                         3'b010, ci[11:10], ci[6], 2'b00, STORE};
          end
          // fp loads/stores and reserved
          default: illegal = 1'b1;
        endcase
      end

      C1: begin
        unique case (ci[15:13])
          3'b000: begin
            // c.addi and c.nop, hints kept as addi hints
            instr_exp = {{7{ci[12]}}, ci[6:2], ci[11:7], 3'b000, ci[11:7], OP_IMM};
          end
          3'b001, 3'b101: begin
            // c.jal links x1, c.j links x0
            instr_exp = {ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11],
                         ci[5:3], {9{ci[12]}}, 4'b0, ~ci[15], JAL};
          end
          3'b010: begin
            // c.li, addi rd, x0, imm
            instr_exp = {{7{ci[12]}}, ci[6:2], 5'b0, 3'b000, ci[11:7], OP_IMM};
          end
          3'b011: begin
            // c.lui, or c.addi16sp when rd is x2
            if (ci[11:7] == 5'd2) begin
              instr_exp = {{3{ci[12]}}, ci[4:3], ci[5], ci[2], ci[6], 4'b0,
                           5'd2, 3'b000, 5'd2, OP_IMM};
            end else begin
              instr_exp = {{15{ci[12]}}, ci[6:2], ci[11:7], LUI};
            end
            // zero immediate is reserved for both
            if ({ci[12], ci[6:2]} == 6'b0) illegal = 1'b1;
          end
          3'b100: begin
            unique case (ci[11:10])
              2'b00, 2'b01: begin
                // c.srli / c.srai, ci[10] picks arithmetic
                instr_exp = {1'b0, ci[10], 5'b0, ci[6:2], 2'b01, ci[9:7],
                             3'b101, 2'b01, ci[9:7], OP_IMM};
                // shamt[5] set is RV64 only
                if (ci[12]) illegal = 1'b1;
              end
              2'b10: begin
                // c.andi
                instr_exp = {{7{ci[12]}}, ci[6:2], 2'b01, ci[9:7],
                             3'b111, 2'b01, ci[9:7], OP_IMM};
              end
              2'b11: begin
                // register-register ops on the compact registers
                unique case ({ci[12], ci[6:5]})
                  3'b000: instr_exp = {7'b0100000, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                       3'b000, 2'b01, ci[9:7], OP};
                  3'b001: instr_exp = {7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                       3'b100, 2'b01, ci[9:7], OP};
                  3'b010: instr_exp = {7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                       3'b110, 2'b01, ci[9:7], OP};
                  3'b011: instr_exp = {7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7],
                                       3'b111, 2'b01, ci[9:7], OP};
                  // c.subw, c.addw and reserved
                  default: illegal = 1'b1;
                endcase
              end
            endcase
          end
          3'b110, 3'b111: begin
            // c.beqz / c.bnez, ci[13] becomes funct3[0]
            instr_exp = {{4{ci[12]}}, ci[6:5], ci[2], 5'b0, 2'b01, ci[9:7],
                         2'b00, ci[13], ci[11:10], ci[4:3], ci[12], BRANCH};
          end
        endcase
      end

      C2: begin
        unique case (ci[15:13])
          3'b000: begin
            // c.slli
            instr_exp = {7'b0, ci[6:2], ci[11:7], 3'b001, ci[11:7], OP_IMM};
            if (ci[12]) illegal = 1'b1;
          end
          3'b010: begin
            // c.lwsp, rd x0 reserved
            instr_exp = {4'b0, ci[3:2], ci[12], ci[6:4], 2'b00, 5'd2,
                         3'b010, ci[11:7], LOAD};
            if (ci[11:7] == 5'b0) illegal = 1'b1;
          end
          3'b100: begin
            if (!ci[12]) begin
              if (ci[6:2] != 5'b0) begin
                // c.mv, add rd, x0, rs2
                instr_exp = {7'b0, ci[6:2], 5'b0, 3'b000, ci[11:7], OP};
              end else begin
                // c.jr, rs1 x0 reserved
                instr_exp = {12'b0, ci[11:7], 3'b000, 5'b0, JALR};
                if (ci[11:7] == 5'b0) illegal = 1'b1;
              end
            end else if (ci[6:2] != 5'b0) begin
              // c.add
              instr_exp = {7'b0, ci[6:2], ci[11:7], 3'b000, ci[11:7], OP};
            end else if (ci[11:7] == 5'b0) begin
              // c.ebreak
              instr_exp = `EBREAK_INSTR;
            end else begin
              // c.jalr, links x1
              instr_exp = {12'b0, ci[11:7], 3'b000, 5'd1, JALR};
            end
          end
          3'b110: begin
            // c.swsp
            instr_exp = {4'b0, ci[8:7], ci[12], ci[6:2], 5'd2, 3'b010,
                         ci[11:9], 2'b00, STORE};
          end
          // fp forms and reserved
          default: illegal = 1'b1;
        endcase
      end

      // full-width instruction, untouched
      default: ;
    endcase
  end

  // slot outputs
  assign slot_o.valid         = cand_valid_i;
  assign slot_o.pc            = cand_pc_i;
  assign slot_o.instr         = instr_exp;
  assign slot_o.is_compressed = (quad != UNCOMPRESSED);
  assign slot_o.illegal       = illegal;

endmodule

// ==== source/instr_aligner.sv ====
////////////////////////////////////////
// fetch word aligner
// up to two candidates per word, carries
// a pending upper half across words
////////////////////////////////////////

`include "fetch_consts.svh"

module instr_aligner import riscv_isa_pkg::*, fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_rdata_i,
  input  logic        flush_i,
  input  addr_t       flush_pc_i,
  output logic        cand0_valid_o,
  output logic [31:0] cand0_raw_o,
  output addr_t       cand0_pc_o,
  output logic        cand1_valid_o,
  output logic [31:0] cand1_raw_o,
  output addr_t       cand1_pc_o
);

  logic [`HALF_W-1:0] lo_half;
  logic [`HALF_W-1:0] hi_half;
  quadrant_e          hi_quad;
  quadrant_e          lo_quad;
  align_state_e       state_q;
  align_state_e       state_d;
  // word address of the next fetch word
  addr_t              exp_pc_q;
  addr_t              exp_pc_d;
  logic [`HALF_W-1:0] pend_half_q;
  logic               pend_load;
  // high half still to be placed, and where
  logic               take_hi;
  logic               hi_to_slot1;
  addr_t              hi_pc;
  logic [31:0]        hi_raw;

  assign lo_half = fetch_rdata_i[`HALF_W-1:0];
  assign hi_half = fetch_rdata_i[31:`HALF_W];
  assign lo_quad = quadrant_e'(lo_half[1:0]);
  assign hi_quad = quadrant_e'(hi_half[1:0]);
  assign hi_pc   = exp_pc_q + 32'd2;
  assign hi_raw  = {{`HALF_W{1'b0}}, hi_half};

  ////////////////////////////////////////
  // candidate selection
  ////////////////////////////////////////

  always_comb begin
    cand0_valid_o = 1'b0;
    cand0_raw_o   = fetch_rdata_i;
    cand0_pc_o    = exp_pc_q;
    cand1_valid_o = 1'b0;
    cand1_raw_o   = hi_raw;
    cand1_pc_o    = hi_pc;
    take_hi       = 1'b0;
    hi_to_slot1   = 1'b1;
    pend_load     = 1'b0;
    state_d       = state_q;
    exp_pc_d      = exp_pc_q;

    if (flush_i) begin
      // word on the bus is dropped, pending half forgotten
      exp_pc_d = {flush_pc_i[31:2], 2'b00};
      if (flush_pc_i[1]) begin
        state_d = SKIP_LOW;
      end else begin
        state_d = ALIGNED;
      end
    end else if (fetch_valid_i) begin
      exp_pc_d = exp_pc_q + 32'd4;
      state_d  = ALIGNED;
      case (state_q)
        ALIGNED: begin
          cand0_valid_o = 1'b1;
          // compressed low half leaves the high half to place
          if (lo_quad != UNCOMPRESSED) begin
            cand0_raw_o = {{`HALF_W{1'b0}}, lo_half};
            take_hi     = 1'b1;
          end
        end
        HALF_PENDING: begin
          // straddling instruction, pc of its first half
          cand0_valid_o = 1'b1;
          cand0_raw_o   = {lo_half, pend_half_q};
          cand0_pc_o    = exp_pc_q - 32'd2;
          take_hi       = 1'b1;
        end
        SKIP_LOW: begin
          // halfword target, high half goes to slot0
          take_hi     = 1'b1;
          hi_to_slot1 = 1'b0;
        end
        default: ;
      endcase

      if (take_hi) begin
        if (hi_quad != UNCOMPRESSED) begin
          if (hi_to_slot1) begin
            cand1_valid_o = 1'b1;
          end else begin
            cand0_valid_o = 1'b1;
            cand0_raw_o   = hi_raw;
            cand0_pc_o    = hi_pc;
          end
        end else begin
          // first half of a 32-bit instruction, wait for next word
          pend_load = 1'b1;
          state_d   = HALF_PENDING;
        end
      end
    end
  end

  ////////////////////////////////////////
  // state and address
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ALIGNED;
      exp_pc_q <= `FETCH_RESET_PC;
    end else begin
      state_q  <= state_d;
      exp_pc_q <= exp_pc_d;
    end
  end

  // pending parcel, only meaningful in HALF_PENDING
  always_ff @(posedge clk_i) begin
    if (pend_load) begin
      pend_half_q <= hi_half;
    end
  end

endmodule

// ==== source/decode_stage_reg.sv ====
////////////////////////////////////////
// register between expansion and decode
// holds both slots, flush drops them
////////////////////////////////////////

module decode_stage_reg import fetch_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          flush_i,
  instr_slot_if.stage   slot0_i,
  instr_slot_if.stage   slot1_i,
  output logic          slot0_valid_o,
  output logic [31:0]   slot0_instr_o,
  output addr_t         slot0_pc_o,
  output logic          slot0_compressed_o,
  output logic          slot0_illegal_o,
  output logic          slot1_valid_o,
  output logic [31:0]   slot1_instr_o,
  output addr_t         slot1_pc_o,
  output logic          slot1_compressed_o,
  output logic          slot1_illegal_o
);

  // valids
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot0_valid_o <= 1'b0;
      slot1_valid_o <= 1'b0;
    end else if (flush_i) begin
      slot0_valid_o <= 1'b0;
      slot1_valid_o <= 1'b0;
    end else begin
      slot0_valid_o <= slot0_i.valid;
      slot1_valid_o <= slot1_i.valid;
    end
  end

  // payload, held while the slot is empty
  always_ff @(posedge clk_i) begin
    if (slot0_i.valid) begin
      slot0_instr_o      <= slot0_i.instr;
      slot0_pc_o         <= slot0_i.pc;
      slot0_compressed_o <= slot0_i.is_compressed;
      slot0_illegal_o    <= slot0_i.illegal;
    end
    if (slot1_i.valid) begin
      slot1_instr_o      <= slot1_i.instr;
      slot1_pc_o         <= slot1_i.pc;
      slot1_compressed_o <= slot1_i.is_compressed;
      slot1_illegal_o    <= slot1_i.illegal;
    end
  end

endmodule

// ==== source/fetch_expand_top.sv ====
////////////////////////////////////////
// instruction expansion stage top
// aligner, two expanders, stage register
////////////////////////////////////////

module fetch_expand_top import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_rdata_i,
  input  logic        flush_i,
  input  addr_t       flush_pc_i,
  output logic        slot0_valid_o,
  output logic [31:0] slot0_instr_o,
  output addr_t       slot0_pc_o,
  output logic        slot0_compressed_o,
  output logic        slot0_illegal_o,
  output logic        slot1_valid_o,
  output logic [31:0] slot1_instr_o,
  output addr_t       slot1_pc_o,
  output logic        slot1_compressed_o,
  output logic        slot1_illegal_o
);

  // aligner to expanders
  logic        cand0_valid;
  logic [31:0] cand0_raw;
  addr_t       cand0_pc;
  logic        cand1_valid;
  logic [31:0] cand1_raw;
  addr_t       cand1_pc;

  instr_slot_if slot0 ();
  instr_slot_if slot1 ();

  instr_aligner i_aligner (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_rdata_i (fetch_rdata_i),
    .flush_i       (flush_i),
    .flush_pc_i    (flush_pc_i),
    .cand0_valid_o (cand0_valid),
    .cand0_raw_o   (cand0_raw),
    .cand0_pc_o    (cand0_pc),
    .cand1_valid_o (cand1_valid),
    .cand1_raw_o   (cand1_raw),
    .cand1_pc_o    (cand1_pc)
  );

  // slot0 may be full-width, slot1 is always compressed
  compressed_decoder i_dec0 (
    .cand_valid_i (cand0_valid),
    .cand_raw_i   (cand0_raw),
    .cand_pc_i    (cand0_pc),
    .slot_o       (slot0)
  );

  compressed_decoder i_dec1 (
    .cand_valid_i (cand1_valid),
    .cand_raw_i   (cand1_raw),
    .cand_pc_i    (cand1_pc),
    .slot_o       (slot1)
  );

  decode_stage_reg i_stage (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .flush_i            (flush_i),
    .slot0_i            (slot0),
    .slot1_i            (slot1),
    .slot0_valid_o      (slot0_valid_o),
    .slot0_instr_o      (slot0_instr_o),
    .slot0_pc_o         (slot0_pc_o),
    .slot0_compressed_o (slot0_compressed_o),
    .slot0_illegal_o    (slot0_illegal_o),
    .slot1_valid_o      (slot1_valid_o),
    .slot1_instr_o      (slot1_instr_o),
    .slot1_pc_o         (slot1_pc_o),
    .slot1_compressed_o (slot1_compressed_o),
    .slot1_illegal_o    (slot1_illegal_o)
  );

endmodule

// ==== test/fetch_expand_assert.sv ====
////////////////////////////////////////
// concurrent checks on the expansion top
// bound into fetch_expand_top
////////////////////////////////////////

module fetch_expand_assert import fetch_pkg::*; (
  input logic         clk_i,
  input logic         arst_n_i,
  input logic         fetch_valid_i,
  input logic [31:0]  fetch_rdata_i,
  input logic         flush_i,
  input logic         slot0_valid_i,
  input logic         slot1_valid_i,
  input align_state_e align_state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // both parcel quadrants must be known on a valid word
  quad_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fetch_valid_i |-> !$isunknown({fetch_rdata_i[17:16], fetch_rdata_i[1:0]}))
    else $error("quadrant bits unknown on a valid fetch word");

  // slots fill in order
  slot_order_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slot1_valid_i |-> slot0_valid_i)
    else $error("slot1 valid without slot0 valid");

  // flush empties the stage register
  flush_clear_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> (!slot0_valid_i && !slot1_valid_i))
    else $error("slot valid in the cycle after a flush");

  // pending half never survives a flush
  flush_state_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> (align_state_i != HALF_PENDING))
    else $error("aligner holds a pending half after a flush");

endmodule

bind fetch_expand_top fetch_expand_assert i_assert (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .fetch_valid_i (fetch_valid_i),
  .fetch_rdata_i (fetch_rdata_i),
  .flush_i       (flush_i),
  .slot0_valid_i (slot0_valid_o),
  .slot1_valid_i (slot1_valid_o),
  .align_state_i (i_aligner.state_q)
);

// ==== test/fetch_expand_tb.sv ====
////////////////////////////////////////
// testbench for the expansion stage
// table of fetch words, idle gaps, checks
////////////////////////////////////////

`include "fetch_consts.svh"

module fetch_expand_tb import riscv_isa_pkg::*, fetch_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS   = 12;
  // reset, then at most 4 cycles per row, plus margin
  localparam int MAX_CYCLES = 8 + NUM_ROWS * 5 + 20;

  // expected contents of one output slot
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    addr_t       pc;
    logic        comp;
    logic        ill;
  } slot_exp_t;

  typedef struct packed {
    logic [31:0] word;
    logic        flush;
    addr_t       flush_pc;
    slot_exp_t   s0;
    slot_exp_t   s1;
  } row_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_rdata_i;
  logic        flush_i;
  addr_t       flush_pc_i;
  logic        slot0_valid_o;
  logic [31:0] slot0_instr_o;
  addr_t       slot0_pc_o;
  logic        slot0_compressed_o;
  logic        slot0_illegal_o;
  logic        slot1_valid_o;
  logic [31:0] slot1_instr_o;
  addr_t       slot1_pc_o;
  logic        slot1_compressed_o;
  logic        slot1_illegal_o;

  row_t        rows[$];
  logic [31:0] rng_state;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  fetch_expand_top i_fetch_expand_top (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic slot_exp_t expect_slot(input logic [31:0] instr, input addr_t pc,
                                            input logic comp, input logic ill);
    return '{1'b1, instr, pc, comp, ill};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic flush, input addr_t fpc,
                         input slot_exp_t s0, input slot_exp_t s1);
    row_t r;
    r.word     = word;
    r.flush    = flush;
    r.flush_pc = fpc;
    r.s0       = s0;
    r.s1       = s1;
    rows.push_back(r);
  endtask

  task automatic check_slot(input string tag, input bit cmp_instr,
                            input logic [31:0] got_instr, input logic [31:0] exp_instr,
                            input addr_t got_pc, input addr_t exp_pc);
    checks += cmp_instr ? 2 : 1;
    if (cmp_instr && got_instr !== exp_instr) begin
      errors++;
      $display("** Error @%0t: %s instr got %08h expected %08h",
               $time, tag, got_instr, exp_instr);
    end
    if (got_pc !== exp_pc) begin
      errors++;
      $display("** Error @%0t: %s pc got %08h expected %08h", $time, tag, got_pc, exp_pc);
    end
  endtask

  task automatic check_flag(input string tag, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @%0t: %s got %b expected %b", $time, tag, got, exp);
    end
  endtask

  task automatic check_opcode(input string tag, input opcode_e got, input opcode_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @%0t: %s got %s (%b) expected %s",
               $time, tag, got.name(), got, exp.name());
    end
  endtask

  task automatic verify_slot(input string tag, input slot_exp_t e, input logic v,
                             input logic [31:0] ins, input addr_t pc,
                             input logic comp, input logic ill);
    check_flag({tag, " valid"}, v, e.valid);
    if (e.valid) begin
      // reserved encodings have no defined expansion, only pc and flags count
      check_slot(tag, !e.ill, ins, e.instr, pc, e.pc);
      check_flag({tag, " compressed"}, comp, e.comp);
      check_flag({tag, " illegal"}, ill, e.ill);
      if (!e.ill) begin
        check_opcode({tag, " opcode"}, opcode_e'(ins[6:0]), opcode_e'(e.instr[6:0]));
      end
    end
  endtask

  task automatic expect_idle();
    check_flag("idle slot0 valid", slot0_valid_o, 1'b0);
    check_flag("idle slot1 valid", slot1_valid_o, 1'b0);
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic fill_table();
    slot_exp_t none;
    none = '0;
    // addi x1, x0, 5 as a plain 32-bit word
    add_row(32'h0050_0093, 1'b0, '0,
            expect_slot(32'h0050_0093, `FETCH_RESET_PC, 1'b0, 1'b0), none);
    // c.addi x8, 1 low, c.lw x9, 4(x10) high
    add_row(32'h4144_0405, 1'b0, '0,
            expect_slot(32'h0014_0413, `FETCH_RESET_PC + 32'h4, 1'b1, 1'b0),
            expect_slot(32'h0045_2483, `FETCH_RESET_PC + 32'h6, 1'b1, 1'b0));
    // c.li x10, 3 then first half of lui x5, 0x12345
    add_row(32'h52b7_450d, 1'b0, '0,
            expect_slot(32'h0030_0513, `FETCH_RESET_PC + 32'h8, 1'b1, 1'b0), none);
    // second half of the lui, then c.nop
    add_row(32'h0001_1234, 1'b0, '0,
            expect_slot(32'h1234_52b7, `FETCH_RESET_PC + 32'ha, 1'b0, 1'b0),
            expect_slot(32'h0000_0013, `FETCH_RESET_PC + 32'he, 1'b1, 1'b0));
    // all-zero parcel, then c.lwsp x1, 8(sp)
    add_row(32'h40a2_0000, 1'b0, '0,
            expect_slot(32'h0, `FETCH_RESET_PC + 32'h10, 1'b1, 1'b1),
            expect_slot(32'h0081_2083, `FETCH_RESET_PC + 32'h12, 1'b1, 1'b0));
    // c.lwsp x0 reserved, then c.jr x1
    add_row(32'h8082_4022, 1'b0, '0,
            expect_slot(32'h0, `FETCH_RESET_PC + 32'h14, 1'b1, 1'b1),
            expect_slot(32'h0000_8067, `FETCH_RESET_PC + 32'h16, 1'b1, 1'b0));
    // c.jr x0 reserved, then c.add x10, x11
    add_row(32'h952e_8002, 1'b0, '0,
            expect_slot(32'h0, `FETCH_RESET_PC + 32'h18, 1'b1, 1'b1),
            expect_slot(32'h00b5_0533, `FETCH_RESET_PC + 32'h1a, 1'b1, 1'b0));
    // c.nop, then a pending half that the flush throws away
    add_row(32'h52b7_0001, 1'b0, '0,
            expect_slot(32'h0000_0013, `FETCH_RESET_PC + 32'h1c, 1'b1, 1'b0), none);
    // flush to a halfword target, word on the bus is dropped
    add_row(32'hdead_beef, 1'b1, 32'h0000_0102, none, none);
    // low half skipped, c.li x10, 3 lands in slot0
    add_row(32'h450d_ffff, 1'b0, '0,
            expect_slot(32'h0030_0513, 32'h0000_0102, 1'b1, 1'b0), none);
    // c.ebreak, then c.jalr x5
    add_row(32'h9282_9002, 1'b0, '0,
            expect_slot(`EBREAK_INSTR, 32'h0000_0104, 1'b1, 1'b0),
            expect_slot(32'h0002_80e7, 32'h0000_0106, 1'b1, 1'b0));
    // c.mv x11, x12, then c.addi x8, 1
    add_row(32'h0405_85b2, 1'b0, '0,
            expect_slot(32'h00c0_05b3, 32'h0000_0108, 1'b1, 1'b0),
            expect_slot(32'h0014_0413, 32'h0000_010a, 1'b1, 1'b0));
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int   idle;
    int   err_before;
    row_t r;
    arst_n_i      = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_rdata_i = '0;
    flush_i       = 1'b0;
    flush_pc_i    = '0;
    rng_state     = 32'h1f43;
    fill_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // nothing comes out before the first word
    err_before = errors;
    repeat (2) begin
      @(negedge clk_i);
      expect_idle();
    end
    $display("reset  %s", (errors == err_before) ? "ok" : "FAILED");

    for (int i = 0; i < rows.size(); i++) begin
      r          = rows[i];
      err_before = errors;
      // drive on the falling edge, result after the next rising edge
      fetch_valid_i = 1'b1;
      fetch_rdata_i = r.word;
      flush_i       = r.flush;
      flush_pc_i    = r.flush_pc;
      @(negedge clk_i);
      fetch_valid_i = 1'b0;
      fetch_rdata_i = '0;
      flush_i       = 1'b0;
      verify_slot("slot0", r.s0, slot0_valid_o, slot0_instr_o, slot0_pc_o,
                  slot0_compressed_o, slot0_illegal_o);
      verify_slot("slot1", r.s1, slot1_valid_o, slot1_instr_o, slot1_pc_o,
                  slot1_compressed_o, slot1_illegal_o);
      // idle gap of 0 to 3 cycles
      rng_state = next_random(rng_state);
      idle      = int'(rng_state[1:0]);
      repeat (idle) begin
        @(negedge clk_i);
        expect_idle();
      end
      $display("row %0d word %08h  %s", i, r.word, (errors == err_before) ? "ok" : "FAILED");
    end

    $display("%0d tests, %0d checks, %0d errors", rows.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
source/riscv_isa_pkg.sv
source/fetch_pkg.sv
source/instr_slot_if.sv
source/compressed_decoder.sv
source/instr_aligner.sv
source/decode_stage_reg.sv
source/fetch_expand_top.sv
test/fetch_expand_assert.sv
test/fetch_expand_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction expansion stage

VERILATOR  ?= verilator
TOP        ?= fetch_expand_tb
RTL_TOP    ?= fetch_expand_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
FAIL_MSG   := Some tests failed

INCDIRS  := $(shell grep '^+incdir' $(FILELIST))
RTL_SRCS := $(filter source/%,$(shell grep -v '^+' $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(INCDIRS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
